/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module scpad_dram_writer_tb -f scpad_dram_writer.f > build.log 2>&1 \
    && ./obj_dir/Vscpad_dram_writer_tb > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "Testbench passed" sim.log 2>/dev/null && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

/* scpad_dram_writer.f */
+incdir+source
source/scpad_types_pkg.sv
source/scpad_sram_bank.sv
source/scpad_writeback_ctrl.sv
source/dram_write_latch.sv
source/scpad_dram_writer.sv
tests/scpad_dram_writer_tb.sv

/* source/dram_write_latch.sv */
`default_nettype none

`include "scpad_macros.svh"

module dram_write_latch (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic                              dram_write,
    input  logic                              dram_valid,
    input  scpad_types_pkg::scpad_row_t       sram_rddata,
    input  logic [`SCPAD_DRAM_ADDR_BITS-1:0]  dram_addr,
    input  logic [`SCPAD_REQ_CNT_BITS-1:0]    num_request,
    input  logic [`SCPAD_NUM_BYTES_BITS-1:0]  num_bytes,
    input  logic                              dram_be_busy,
    output logic                              dram_write_req_valid,
    output logic [`SCPAD_BEAT_BITS-1:0]       dram_write_req_wdata,
    output logic [`SCPAD_DRAM_ADDR_BITS-1:0]  dram_write_req_addr,
    output logic [`SCPAD_NUM_BYTES_BITS-1:0]  dram_write_req_num_bytes,
    output logic                              dram_write_req_latched
);

    // byte offset inside a beat, then beat index inside a row
    localparam int BYTE_OFS_BITS = $clog2(`SCPAD_BEAT_BITS / 8);
    localparam int ROW_OFS_BITS  = BYTE_OFS_BITS + `SCPAD_BEAT_IDX_BITS;

    // beats already registered for this row
    logic [`SCPAD_REQ_CNT_BITS-1:0]  req_cnt;
    logic [`SCPAD_BEAT_IDX_BITS-1:0] beat_idx;
    logic                            active;
    logic                            more_beats;
    logic                            load_beat;

    assign active     = dram_write && dram_valid;
    assign more_beats = (req_cnt != num_request);
    assign beat_idx   = req_cnt[`SCPAD_BEAT_IDX_BITS-1:0];

    // a new beat only goes in when the backend can take the current one
    assign load_beat = active && more_beats && !dram_be_busy;

    // every beat registered and the last one has left the register
    assign dram_write_req_latched = active && !more_beats && !dram_write_req_valid;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            req_cnt              <= '0;
            dram_write_req_valid <= 1'b0;
        end else if (dram_write_req_latched) begin
            req_cnt              <= '0;
            dram_write_req_valid <= 1'b0;
        end else if (!dram_be_busy) begin
            if (load_beat) begin
                req_cnt              <= req_cnt + 1'b1;
                dram_write_req_valid <= 1'b1;
            end else begin
                // present beat accepted with nothing behind it
                dram_write_req_valid <= 1'b0;
            end
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        if (load_beat) begin
            dram_write_req_wdata     <= sram_rddata.beats[beat_idx];
            dram_write_req_addr      <= {dram_addr[`SCPAD_DRAM_ADDR_BITS-1:ROW_OFS_BITS],
                                         beat_idx,
                                         {BYTE_OFS_BITS{1'b0}}};
            dram_write_req_num_bytes <= num_bytes;
        end
    end

    // a stalled beat must not move until the backend takes it
    property p_hold_under_busy;
        @(posedge clk) disable iff (!n_rst)
        (dram_write_req_valid && dram_be_busy) |=>
            (dram_write_req_valid
             && $stable(dram_write_req_wdata)
             && $stable(dram_write_req_addr)
             && $stable(dram_write_req_num_bytes));
    endproperty

    a_hold_under_busy: assert property (p_hold_under_busy)
        else $error("beat changed under busy, addr %h", dram_write_req_addr);

    // never more than one row of beats
    property p_cnt_bound;
        @(posedge clk) disable iff (!n_rst)
        req_cnt <= `SCPAD_BEATS;
    endproperty

    a_cnt_bound: assert property (p_cnt_bound)
        else $error("beat counter overflow: %h", req_cnt);

endmodule

`default_nettype wire

/* source/scpad_dram_writer.sv */
`default_nettype none

`include "scpad_macros.svh"

module scpad_dram_writer (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic                              sram_wr_en,
    input  logic [`SCPAD_ROW_IDX_BITS-1:0]    sram_wr_row,
    input  scpad_types_pkg::scpad_row_t       sram_wr_data,
    input  logic                              wb_start,
    input  logic [`SCPAD_ROW_IDX_BITS-1:0]    wb_row,
    input  logic [`SCPAD_DRAM_ADDR_BITS-1:0]  wb_dram_addr,
    input  logic [`SCPAD_REQ_CNT_BITS-1:0]    wb_num_request,
    input  logic [`SCPAD_NUM_BYTES_BITS-1:0]  wb_num_bytes,
    input  logic                              dram_be_busy,
    output logic                              wb_busy,
    output logic                              wb_done,
    output logic                              dram_write_req_valid,
    output logic [`SCPAD_BEAT_BITS-1:0]       dram_write_req_wdata,
    output logic [`SCPAD_DRAM_ADDR_BITS-1:0]  dram_write_req_addr,
    output logic [`SCPAD_NUM_BYTES_BITS-1:0]  dram_write_req_num_bytes
);
    import scpad_types_pkg::*;

    // controller to bank
    logic                             rd_en;
    logic [`SCPAD_ROW_IDX_BITS-1:0]   rd_row;
    scpad_row_t                       rd_data;

    // controller to latch
    logic                             dram_write;
    logic                             dram_valid;
    scpad_row_t                       sram_rddata;
    logic [`SCPAD_DRAM_ADDR_BITS-1:0] dram_addr;
    logic [`SCPAD_REQ_CNT_BITS-1:0]   num_request;
    logic [`SCPAD_NUM_BYTES_BITS-1:0] num_bytes;

    // latch back to controller
    logic                             dram_write_req_latched;

    scpad_sram_bank sram_bank_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr_en   (sram_wr_en),
        .wr_row  (sram_wr_row),
        .wr_data (sram_wr_data),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

    scpad_writeback_ctrl wb_ctrl_i (
        .clk                    (clk),
        .n_rst                  (n_rst),
        .wb_start               (wb_start),
        .wb_row                 (wb_row),
        .wb_dram_addr           (wb_dram_addr),
        .wb_num_request         (wb_num_request),
        .wb_num_bytes           (wb_num_bytes),
        .rd_data                (rd_data),
        .dram_write_req_latched (dram_write_req_latched),
        .wb_busy                (wb_busy),
        .wb_done                (wb_done),
        .rd_en                  (rd_en),
        .rd_row                 (rd_row),
        .dram_write             (dram_write),
        .dram_valid             (dram_valid),
        .sram_rddata            (sram_rddata),
        .dram_addr              (dram_addr),
        .num_request            (num_request),
        .num_bytes              (num_bytes)
    );

    dram_write_latch write_latch_i (
        .clk                      (clk),
        .n_rst                    (n_rst),
        .dram_write               (dram_write),
        .dram_valid               (dram_valid),
        .sram_rddata              (sram_rddata),
        .dram_addr                (dram_addr),
        .num_request              (num_request),
        .num_bytes                (num_bytes),
        .dram_be_busy             (dram_be_busy),
        .dram_write_req_valid     (dram_write_req_valid),
        .dram_write_req_wdata     (dram_write_req_wdata),
        .dram_write_req_addr      (dram_write_req_addr),
        .dram_write_req_num_bytes (dram_write_req_num_bytes),
        .dram_write_req_latched   (dram_write_req_latched)
    );

endmodule

`default_nettype wire

/* source/scpad_macros.svh */
`ifndef SCPAD_MACROS_SVH
`define SCPAD_MACROS_SVH

// scratchpad row geometry
`define SCPAD_ROW_BITS        512
`define SCPAD_BEAT_BITS       64
`define SCPAD_BEATS           8

// beat index into a row
`define SCPAD_BEAT_IDX_BITS   3

// holds a beat count from 0 up to 8
`define SCPAD_REQ_CNT_BITS    4

// dram side byte address
`define SCPAD_DRAM_ADDR_BITS  32

// sram bank depth and row index
`define SCPAD_ROWS            16
`define SCPAD_ROW_IDX_BITS    4

// byte count per beat request, up to 64
`define SCPAD_NUM_BYTES_BITS  7

`endif

/* source/scpad_sram_bank.sv */
`default_nettype none

`include "scpad_macros.svh"

module scpad_sram_bank (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            wr_en,
    input  logic [`SCPAD_ROW_IDX_BITS-1:0]  wr_row,
    input  scpad_types_pkg::scpad_row_t     wr_data,
    input  logic                            rd_en,
    input  logic [`SCPAD_ROW_IDX_BITS-1:0]  rd_row,
    output scpad_types_pkg::scpad_row_t     rd_data
);
    import scpad_types_pkg::*;

    // row storage
    scpad_row_t rows [`SCPAD_ROWS];

    // single cycle write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            rows[wr_row] <= wr_data;
        end
    end

    // registered read, data shows up the cycle after rd_en
    // a read of a row written on the same edge returns the old contents
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= rows[rd_row];
        end
    end

    // row index must be known whenever a read is issued
    property p_rd_row_known;
        @(posedge clk) disable iff (!n_rst)
        rd_en |-> !$isunknown(rd_row);
    endproperty

    a_rd_row_known: assert property (p_rd_row_known)
        else $error("sram bank read with unknown row index %h", rd_row);

endmodule

`default_nettype wire

/* source/scpad_types_pkg.sv */
`default_nettype none

`include "scpad_macros.svh"

package scpad_types_pkg;

    // one scratchpad row
    // flat view for storage and transport
    // beat view for slicing into dram writes, beat 0 in the low bits
    typedef union packed {
        logic [`SCPAD_ROW_BITS-1:0] flat;
        logic [`SCPAD_BEATS-1:0][`SCPAD_BEAT_BITS-1:0] beats;
    } scpad_row_t;

endpackage

`default_nettype wire

/* source/scpad_writeback_ctrl.sv */
`default_nettype none

`include "scpad_macros.svh"

module scpad_writeback_ctrl (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic                              wb_start,
    input  logic [`SCPAD_ROW_IDX_BITS-1:0]    wb_row,
    input  logic [`SCPAD_DRAM_ADDR_BITS-1:0]  wb_dram_addr,
    input  logic [`SCPAD_REQ_CNT_BITS-1:0]    wb_num_request,
    input  logic [`SCPAD_NUM_BYTES_BITS-1:0]  wb_num_bytes,
    input  scpad_types_pkg::scpad_row_t       rd_data,
    input  logic                              dram_write_req_latched,
    output logic                              wb_busy,
    output logic                              wb_done,
    output logic                              rd_en,
    output logic [`SCPAD_ROW_IDX_BITS-1:0]    rd_row,
    output logic                              dram_write,
    output logic                              dram_valid,
    output scpad_types_pkg::scpad_row_t       sram_rddata,
    output logic [`SCPAD_DRAM_ADDR_BITS-1:0]  dram_addr,
    output logic [`SCPAD_REQ_CNT_BITS-1:0]    num_request,
    output logic [`SCPAD_NUM_BYTES_BITS-1:0]  num_bytes
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_READ   = 2'd1;
    localparam logic [1:0] ST_STREAM = 2'd2;

    logic [1:0] state;
    logic [1:0] nxt_state;
    logic       cmd_accept;
    logic       stream_end;

    // start only counts while idle
    assign cmd_accept = wb_start && (state == ST_IDLE);
    assign stream_end = (state == ST_STREAM) && dram_write_req_latched;

    // sram read goes out in the same cycle as the start strobe
    assign rd_en  = cmd_accept;
    assign rd_row = wb_row;

    assign wb_busy    = (state != ST_IDLE);
    assign dram_write = (state == ST_STREAM);
    assign dram_valid = (state == ST_STREAM);

    always_comb begin
        nxt_state = state;
        case (state)
            ST_IDLE: begin
                if (wb_start) begin
                    nxt_state = ST_READ;
                end
            end
            ST_READ: begin
                // read data is on rd_data now, captured at the next edge
                nxt_state = ST_STREAM;
            end
            ST_STREAM: begin
                if (dram_write_req_latched) begin
                    nxt_state = ST_IDLE;
                end
            end
            default: begin
                nxt_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= ST_IDLE;
            wb_done <= 1'b0;
        end else begin
            state   <= nxt_state;
            wb_done <= stream_end;
        end
    end

    // command fields, held for the whole writeback
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            dram_addr   <= wb_dram_addr;
            num_request <= wb_num_request;
            num_bytes   <= wb_num_bytes;
        end
    end

    // row from the bank, held while streaming
    always_ff @(posedge clk) begin
        if (state == ST_READ) begin
            sram_rddata.flat <= rd_data.flat;
        end
    end

    // done is a single cycle strobe per command
    property p_done_pulse;
        @(posedge clk) disable iff (!n_rst)
        wb_done |=> !wb_done;
    endproperty

    a_done_pulse: assert property (p_done_pulse)
        else $error("wb_done held high for more than one cycle");

    // beat count stays in range for the whole stream
    property p_num_request_range;
        @(posedge clk) disable iff (!n_rst)
        dram_valid |-> (num_request >= 1 && num_request <= `SCPAD_BEATS);
    endproperty

    a_num_request_range: assert property (p_num_request_range)
        else $error("num_request out of range while streaming: %h", num_request);

endmodule

`default_nettype wire

/* tests/scpad_dram_writer_tb.sv */
`default_nettype none

`include "scpad_macros.svh"

module scpad_dram_writer_tb;
    import scpad_types_pkg::*;

    localparam logic [31:0] SEED         = 32'he429c31b;
    localparam int          DONE_TIMEOUT = 500;

    logic                              clk;
    logic                              n_rst;
    logic                              sram_wr_en;
    logic [`SCPAD_ROW_IDX_BITS-1:0]    sram_wr_row;
    scpad_row_t                        sram_wr_data;
    logic                              wb_start;
    logic [`SCPAD_ROW_IDX_BITS-1:0]    wb_row;
    logic [`SCPAD_DRAM_ADDR_BITS-1:0]  wb_dram_addr;
    logic [`SCPAD_REQ_CNT_BITS-1:0]    wb_num_request;
    logic [`SCPAD_NUM_BYTES_BITS-1:0]  wb_num_bytes;
    logic                              dram_be_busy;
    logic                              wb_busy;
    logic                              wb_done;
    logic                              dram_write_req_valid;
    logic [`SCPAD_BEAT_BITS-1:0]       dram_write_req_wdata;
    logic [`SCPAD_DRAM_ADDR_BITS-1:0]  dram_write_req_addr;
    logic [`SCPAD_NUM_BYTES_BITS-1:0]  dram_write_req_num_bytes;

    // reference copy of every row written into the bank
    logic [`SCPAD_ROW_BITS-1:0] mirror [`SCPAD_ROWS];

    // command the DUT is working on
    logic [`SCPAD_ROW_IDX_BITS-1:0]    cur_row;
    logic [`SCPAD_DRAM_ADDR_BITS-1:0]  cur_addr;
    logic [`SCPAD_REQ_CNT_BITS-1:0]    cur_req;
    logic [`SCPAD_NUM_BYTES_BITS-1:0]  cur_bytes;
    logic                              cmd_issued;

    // beats accepted so far for the current command
    logic [`SCPAD_REQ_CNT_BITS-1:0]    beat_cnt;
    logic                              done_seen;
    logic                              accept;
    logic                              start_taken;

    int busy_pct;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;

    scpad_dram_writer dut_i (
        .clk                      (clk),
        .n_rst                    (n_rst),
        .sram_wr_en               (sram_wr_en),
        .sram_wr_row              (sram_wr_row),
        .sram_wr_data             (sram_wr_data),
        .wb_start                 (wb_start),
        .wb_row                   (wb_row),
        .wb_dram_addr             (wb_dram_addr),
        .wb_num_request           (wb_num_request),
        .wb_num_bytes             (wb_num_bytes),
        .dram_be_busy             (dram_be_busy),
        .wb_busy                  (wb_busy),
        .wb_done                  (wb_done),
        .dram_write_req_valid     (dram_write_req_valid),
        .dram_write_req_wdata     (dram_write_req_wdata),
        .dram_write_req_addr      (dram_write_req_addr),
        .dram_write_req_num_bytes (dram_write_req_num_bytes)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign accept      = dram_write_req_valid && !dram_be_busy;
    assign start_taken = wb_start && !wb_busy;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            beat_cnt  <= '0;
            done_seen <= 1'b0;
        end else if (start_taken) begin
            beat_cnt  <= '0;
            done_seen <= 1'b0;
        end else begin
            if (accept) begin
                beat_cnt <= beat_cnt + 4'd1;
            end
            if (wb_done) begin
                done_seen <= 1'b1;
            end
        end
    end

    // beat k is bits 64k+63 down to 64k of the row
    function automatic logic [`SCPAD_BEAT_BITS-1:0] expected_wdata(
        input logic [`SCPAD_ROW_BITS-1:0]  row,
        input logic [`SCPAD_REQ_CNT_BITS-1:0] idx
    );
        return row[int'(idx) * `SCPAD_BEAT_BITS +: `SCPAD_BEAT_BITS];
    endfunction

    // bits 5:3 carry the beat index, bits 2:0 are zero
    function automatic logic [`SCPAD_DRAM_ADDR_BITS-1:0] expected_addr(
        input logic [`SCPAD_DRAM_ADDR_BITS-1:0] base,
        input logic [`SCPAD_REQ_CNT_BITS-1:0]   idx
    );
        return {base[`SCPAD_DRAM_ADDR_BITS-1:6], idx[2:0], 3'b000};
    endfunction

    a_reset_quiet: assert property (@(posedge clk) disable iff (!n_rst)
        !cmd_issued |-> (!dram_write_req_valid && !wb_busy && !wb_done))
        else begin
            err_cnt++;
            $display("outputs not quiet after reset: valid %h busy %h done %h",
                     dram_write_req_valid, wb_busy, wb_done);
        end

    a_beat_wdata: assert property (@(posedge clk) disable iff (!n_rst)
        accept |-> dram_write_req_wdata == expected_wdata(mirror[cur_row], beat_cnt))
        else begin
            err_cnt++;
            $display("Mismatch dram_write_req_wdata: got %h expected %h", dram_write_req_wdata,
                     expected_wdata(mirror[cur_row], beat_cnt));
        end

    a_beat_addr: assert property (@(posedge clk) disable iff (!n_rst)
        accept |-> dram_write_req_addr == expected_addr(cur_addr, beat_cnt))
        else begin
            err_cnt++;
            $display("Mismatch dram_write_req_addr: got %h expected %h", dram_write_req_addr,
                     expected_addr(cur_addr, beat_cnt));
        end

    a_beat_bytes: assert property (@(posedge clk) disable iff (!n_rst)
        accept |-> dram_write_req_num_bytes == cur_bytes)
        else begin
            err_cnt++;
            $display("Mismatch dram_write_req_num_bytes: got %h expected %h",
                     dram_write_req_num_bytes, cur_bytes);
        end

    a_no_extra_beat: assert property (@(posedge clk) disable iff (!n_rst)
        accept |-> beat_cnt < cur_req)
        else begin
            err_cnt++;
            $display("beat accepted beyond the %0d requested", cur_req);
        end

    a_hold_under_busy: assert property (@(posedge clk) disable iff (!n_rst)
        (dram_write_req_valid && dram_be_busy) |=>
            (dram_write_req_valid && $stable(dram_write_req_wdata)
             && $stable(dram_write_req_addr) && $stable(dram_write_req_num_bytes)))
        else begin
            err_cnt++;
            $display("stalled beat dropped or changed while the backend was busy");
        end

    a_idle_no_beat: assert property (@(posedge clk) disable iff (!n_rst)
        !wb_busy |-> !dram_write_req_valid)
        else begin
            err_cnt++;
            $display("beat presented while no writeback was running");
        end

    a_busy_after_start: assert property (@(posedge clk) disable iff (!n_rst)
        start_taken |=> wb_busy)
        else begin
            err_cnt++;
            $display("wb_busy did not rise after an accepted start");
        end

    a_done_after_last: assert property (@(posedge clk) disable iff (!n_rst)
        wb_done |-> (beat_cnt == cur_req && !wb_busy && !done_seen))
        else begin
            err_cnt++;
            $display("wb_done early or repeated: %0d of %0d beats, busy %h",
                     beat_cnt, cur_req, wb_busy);
        end

    // busy pattern is redrawn on every falling edge
    task automatic advance_cycle();
        @(negedge clk);
        dram_be_busy = (busy_pct > 0) && (int'($urandom_range(99, 0)) < busy_pct);
    endtask

    task automatic write_row(input logic [`SCPAD_ROW_IDX_BITS-1:0] row);
        logic [`SCPAD_ROW_BITS-1:0] data;
        int w;
        for (w = 0; w < `SCPAD_ROW_BITS / 32; w++) begin
            data[w*32 +: 32] = $urandom;
        end
        mirror[row]       = data;
        sram_wr_en        = 1'b1;
        sram_wr_row       = row;
        sram_wr_data.flat = data;
        advance_cycle();
        sram_wr_en        = 1'b0;
    endtask

    task automatic run_command(input logic [`SCPAD_REQ_CNT_BITS-1:0] req,
                               input bit poke_while_busy);
        bit seen;
        int cyc;
        cmd_issued     = 1'b1;
        cur_row        = 4'($urandom_range(`SCPAD_ROWS - 1, 0));
        cur_addr       = $urandom;
        cur_req        = req;
        cur_bytes      = 7'($urandom_range(64, 1));
        wb_start       = 1'b1;
        wb_row         = cur_row;
        wb_dram_addr   = cur_addr;
        wb_num_request = cur_req;
        wb_num_bytes   = cur_bytes;
        advance_cycle();
        wb_start = 1'b0;
        if (poke_while_busy) begin
            // second start lands while the row read is still in flight
            wb_start       = 1'b1;
            wb_row         = cur_row + 4'd1;
            wb_dram_addr   = ~cur_addr;
            wb_num_request = 4'd8;
            wb_num_bytes   = ~cur_bytes;
            advance_cycle();
            wb_start = 1'b0;
        end
        seen = 1'b0;
        cyc  = 0;
        while (!seen && cyc < DONE_TIMEOUT) begin
            advance_cycle();
            seen = wb_done;
            cyc++;
        end
        if (!seen) begin
            err_cnt++;
            $display("timeout: no wb_done within %0d cycles of wb_start", DONE_TIMEOUT);
        end
        advance_cycle();
        advance_cycle();
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int errs;
        int i;
        void'($urandom(SEED));
        err_cnt        = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        busy_pct       = 0;
        n_rst          = 1'b0;
        sram_wr_en     = 1'b0;
        sram_wr_row    = '0;
        sram_wr_data   = '0;
        wb_start       = 1'b0;
        wb_row         = '0;
        wb_dram_addr   = '0;
        wb_num_request = '0;
        wb_num_bytes   = '0;
        dram_be_busy   = 1'b0;
        cmd_issued     = 1'b0;
        cur_row        = '0;
        cur_addr       = '0;
        cur_req        = '0;
        cur_bytes      = '0;
        repeat (16) @(negedge clk);
        n_rst = 1'b1;

        errs = err_cnt;
        for (i = 0; i < 20; i++) begin
            advance_cycle();
        end
        close_test("reset_state", errs);

        errs = err_cnt;
        for (i = 0; i < `SCPAD_ROWS; i++) begin
            write_row(4'(i));
        end
        for (i = 0; i < 4; i++) begin
            run_command(4'd8, 1'b0);
        end
        close_test("full_row", errs);

        errs = err_cnt;
        for (i = 0; i < 7; i++) begin
            run_command(4'($urandom_range(7, 1)), 1'b0);
        end
        close_test("partial_row", errs);

        errs = err_cnt;
        busy_pct = 50;
        for (i = 0; i < 4; i++) begin
            write_row(4'($urandom_range(`SCPAD_ROWS - 1, 0)));
            run_command(4'd8, 1'b0);
            run_command(4'($urandom_range(8, 1)), 1'b0);
        end
        close_test("back_pressure", errs);

        errs = err_cnt;
        busy_pct = 30;
        for (i = 0; i < 4; i++) begin
            run_command(4'($urandom_range(8, 1)), 1'b1);
        end
        busy_pct = 0;
        for (i = 0; i < 10; i++) begin
            advance_cycle();
        end
        close_test("completion", errs);

        $display("tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
